//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tomasulo
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/dispatch_if.sv
`default_nettype none

// issue unit to reservation station transfer
interface dispatch_if;
  import tomasulo_pkg::*;

  logic     valid;
  alu_op_e  op;
  rob_tag_t tag;         // destination ROB slot
  word_t    src1_value;
  rob_tag_t src1_tag;
  logic     src1_ready;
  word_t    src2_value;
  rob_tag_t src2_tag;
  logic     src2_ready;
  word_t    imm;
  logic     free;        // at least one empty entry

  modport producer (
    output valid, op, tag, src1_value, src1_tag, src1_ready,
    output src2_value, src2_tag, src2_ready, imm,
    input  free
  );

  modport buffer (
    input  valid, op, tag, src1_value, src1_tag, src1_ready,
    input  src2_value, src2_tag, src2_ready, imm,
    output free
  );

endinterface

`default_nettype wire

//--- common/rob_if.sv
`default_nettype none

interface rob_if;
  import tomasulo_pkg::*;

  // allocation and operand lookup from the issue side
  logic      alloc;
  reg_addr_t alloc_rd;
  rob_tag_t  lookup1_tag;
  rob_tag_t  lookup2_tag;

  rob_tag_t  tail_tag;
  logic      full;
  logic      lookup1_done;
  word_t     lookup1_value;
  logic      lookup2_done;
  word_t     lookup2_value;

  // one cycle pulse when the head retires
  logic      commit_valid;
  reg_addr_t commit_rd;
  rob_tag_t  commit_tag;
  word_t     commit_value;

  modport issue (
    output alloc, alloc_rd, lookup1_tag, lookup2_tag,
    input  tail_tag, full, lookup1_done, lookup1_value, lookup2_done, lookup2_value,
    input  commit_valid, commit_rd, commit_tag, commit_value
  );

  modport buffer (
    input  alloc, alloc_rd, lookup1_tag, lookup2_tag,
    output tail_tag, full, lookup1_done, lookup1_value, lookup2_done, lookup2_value,
    output commit_valid, commit_rd, commit_tag, commit_value
  );

endinterface

`default_nettype wire

//--- common/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

  // sizes shared by every unit
  localparam int ROB_DEPTH_MAX = 32;
  localparam int NUM_REGS      = 32;

  // data word, signed so slt compares directly
  typedef logic signed [31:0] word_t;

  typedef logic [4:0] reg_addr_t;

  // rename tag is a reorder buffer slot index
  typedef logic [$clog2(ROB_DEPTH_MAX)-1:0] rob_tag_t;

  // ALU opcodes, addi takes the immediate as operand b
  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_addi
  } alu_op_e;

  // common data bus, one result per cycle
  typedef struct packed {
    logic     valid;
    rob_tag_t tag;   // producing ROB slot
    word_t    value;
  } cdb_t;

endpackage

`default_nettype wire

//--- hw/alu_unit.sv
`default_nettype none

module alu_unit #(
  parameter int alu_latency = 2  // at least 1
) (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         issue_valid,
  input  wire tomasulo_pkg::alu_op_e  issue_op,
  input  wire tomasulo_pkg::rob_tag_t issue_tag,
  input  wire tomasulo_pkg::word_t    issue_a,
  input  wire tomasulo_pkg::word_t    issue_b,
  output tomasulo_pkg::cdb_t          cdb
);
  import tomasulo_pkg::*;

  word_t                  result;
  logic [alu_latency-1:0] valid_q;
  rob_tag_t               tag_q   [alu_latency];
  word_t                  value_q [alu_latency];

  always_comb begin
    case (issue_op)
      op_add, op_addi: result = issue_a + issue_b;
      op_sub:          result = issue_a - issue_b;
      op_and:          result = issue_a & issue_b;
      op_or:           result = issue_a | issue_b;
      op_xor:          result = issue_a ^ issue_b;
      op_slt:          result = (issue_a < issue_b) ? word_t'(1) : word_t'(0); // signed
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= issue_valid;
      for (int i = 1; i < alu_latency; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // result rides along with its tag
  always_ff @(posedge clock) begin
    tag_q[0]   <= issue_tag;
    value_q[0] <= result;
    for (int i = 1; i < alu_latency; i++) begin
      tag_q[i]   <= tag_q[i-1];
      value_q[i] <= value_q[i-1];
    end
  end

  assign cdb = '{valid: valid_q[alu_latency-1],
                 tag:   tag_q[alu_latency-1],
                 value: value_q[alu_latency-1]};

endmodule

`default_nettype wire

//--- hw/issue_unit.sv
`default_nettype none

module issue_unit #(
  parameter int rob_depth = 8
) (
  input  wire                          clock,
  input  wire                          reset,
  input  wire                          instr_req,
  input  wire tomasulo_pkg::alu_op_e   instr_op,
  input  wire tomasulo_pkg::reg_addr_t instr_rd,
  input  wire tomasulo_pkg::reg_addr_t instr_rs1,
  input  wire tomasulo_pkg::reg_addr_t instr_rs2,
  input  wire tomasulo_pkg::word_t     instr_imm,
  output logic                         instr_ack,
  input  wire tomasulo_pkg::cdb_t      cdb,
  dispatch_if.producer                 dispatch,
  rob_if.issue                         rob
);
  import tomasulo_pkg::*;

  localparam int idx_w = $clog2(rob_depth);

  typedef enum logic {st_idle, st_ack} issue_state_e;

  issue_state_e        state;
  word_t               regfile [NUM_REGS];
  logic [NUM_REGS-1:0] rat_busy;              // register waits on a ROB slot
  logic [idx_w-1:0]    rat_tag [NUM_REGS];
  logic                fire;
  rob_tag_t            src1_tag;
  rob_tag_t            src2_tag;

  // value priority: register file, then CDB this cycle, then a done ROB slot
  function automatic logic [32:0] fetch_operand(input logic renamed, input word_t rf_value,
                                                input rob_tag_t tag, input logic rob_done,
                                                input word_t rob_value, input cdb_t bus);
    logic [32:0] operand;
    if (!renamed)
      operand = {1'b1, rf_value};
    else if (bus.valid && bus.tag == tag)
      operand = {1'b1, bus.value};
    else if (rob_done)
      operand = {1'b1, rob_value};
    else
      operand = {1'b0, rob_value};  // still pending, station snoops later
    return operand;
  endfunction

  assign fire      = (state == st_idle) && instr_req && !rob.full && dispatch.free;
  assign instr_ack = (state == st_ack);

  assign src1_tag = rob_tag_t'(rat_tag[instr_rs1]);
  assign src2_tag = rob_tag_t'(rat_tag[instr_rs2]);

  assign rob.alloc       = fire;
  assign rob.alloc_rd    = instr_rd;
  assign rob.lookup1_tag = src1_tag;
  assign rob.lookup2_tag = src2_tag;

  assign dispatch.valid    = fire;
  assign dispatch.op       = instr_op;
  assign dispatch.tag      = rob.tail_tag; // rd renames to the new slot
  assign dispatch.imm      = instr_imm;
  assign dispatch.src1_tag = src1_tag;
  assign dispatch.src2_tag = src2_tag;

  assign {dispatch.src1_ready, dispatch.src1_value} =
    fetch_operand(rat_busy[instr_rs1], regfile[instr_rs1], src1_tag,
                  rob.lookup1_done, rob.lookup1_value, cdb);
  assign {dispatch.src2_ready, dispatch.src2_value} =
    fetch_operand(rat_busy[instr_rs2], regfile[instr_rs2], src2_tag,
                  rob.lookup2_done, rob.lookup2_value, cdb);

  // four-phase ack, low again one cycle after req drops
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (fire) state <= st_ack;
        st_ack:  if (!instr_req) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regfile[i] <= word_t'(i);
      end
      rat_busy <= '0;
    end else begin
      if (rob.commit_valid && rob.commit_rd != '0) begin
        regfile[rob.commit_rd] <= rob.commit_value;
        // a younger rename keeps the mapping
        if (rat_tag[rob.commit_rd] == rob.commit_tag[idx_w-1:0])
          rat_busy[rob.commit_rd] <= 1'b0;
      end
      if (fire && instr_rd != '0)
        rat_busy[instr_rd] <= 1'b1;  // overrides a same-cycle clear
    end
  end

  always_ff @(posedge clock) begin
    if (fire && instr_rd != '0)
      rat_tag[instr_rd] <= rob.tail_tag[idx_w-1:0];
  end

endmodule

`default_nettype wire

//--- hw/reorder_buffer.sv
`default_nettype none

module reorder_buffer #(
  parameter int rob_depth = 8
) (
  input  wire                     clock,
  input  wire                     reset,
  rob_if.buffer                   rob,
  input  wire tomasulo_pkg::cdb_t cdb,
  output logic                    commit_req,
  output tomasulo_pkg::reg_addr_t commit_rd,
  output tomasulo_pkg::word_t     commit_value,
  input  wire                     commit_ack
);
  import tomasulo_pkg::*;

  localparam int idx_w = $clog2(rob_depth);

  typedef enum logic [1:0] {c_idle, c_req, c_release} commit_state_e;

  commit_state_e        cstate;
  logic [idx_w:0]       head;    // extra bit tells full from empty
  logic [idx_w:0]       tail;
  logic [rob_depth-1:0] done;
  reg_addr_t            rd_q [rob_depth];
  word_t                value_q [rob_depth];
  logic [idx_w-1:0]     head_idx;
  logic [idx_w-1:0]     tail_idx;
  logic                 empty;
  logic                 retire;

  assign head_idx = head[idx_w-1:0];
  assign tail_idx = tail[idx_w-1:0];
  assign empty    = (head == tail);

  assign rob.full     = (head_idx == tail_idx) && (head[idx_w] != tail[idx_w]);
  assign rob.tail_tag = rob_tag_t'(tail_idx);

  assign rob.lookup1_done  = done[rob.lookup1_tag[idx_w-1:0]];
  assign rob.lookup1_value = value_q[rob.lookup1_tag[idx_w-1:0]];
  assign rob.lookup2_done  = done[rob.lookup2_tag[idx_w-1:0]];
  assign rob.lookup2_value = value_q[rob.lookup2_tag[idx_w-1:0]];

  assign retire       = (cstate == c_req) && commit_ack; // head leaves on ack
  assign commit_req   = (cstate == c_req);
  assign commit_rd    = rd_q[head_idx];
  assign commit_value = value_q[head_idx];

  assign rob.commit_valid = retire;
  assign rob.commit_rd    = commit_rd;
  assign rob.commit_tag   = rob_tag_t'(head_idx);
  assign rob.commit_value = commit_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      cstate <= c_idle;
      head   <= '0;
      tail   <= '0;
      done   <= '0;
    end else begin
      case (cstate)
        c_idle:    if (!empty && done[head_idx]) cstate <= c_req;
        c_req:     if (commit_ack) cstate <= c_release;
        c_release: if (!commit_ack) cstate <= c_idle;  // wait for ack to drop
        default:   cstate <= c_idle;
      endcase
      if (retire) begin
        head           <= head + 1'b1;
        done[head_idx] <= 1'b0;
      end
      if (cdb.valid)
        done[cdb.tag[idx_w-1:0]] <= 1'b1;
      if (rob.alloc) begin
        tail           <= tail + 1'b1;
        done[tail_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rob.alloc)
      rd_q[tail_idx] <= rob.alloc_rd;
    if (cdb.valid)
      value_q[cdb.tag[idx_w-1:0]] <= cdb.value;
  end

endmodule

`default_nettype wire

//--- hw/rs/reservation_station.sv
`default_nettype none

module reservation_station #(
  parameter int rs_depth = 3
) (
  input  wire                     clock,
  input  wire                     reset,
  dispatch_if.buffer              dispatch,
  input  wire tomasulo_pkg::cdb_t cdb,
  output logic                    issue_valid,
  output tomasulo_pkg::alu_op_e   issue_op,
  output tomasulo_pkg::rob_tag_t  issue_tag,
  output tomasulo_pkg::word_t     issue_a,
  output tomasulo_pkg::word_t     issue_b
);
  import tomasulo_pkg::*;

  localparam int age_w = $clog2(rs_depth + 1);
  localparam int sel_w = (rs_depth > 1) ? $clog2(rs_depth) : 1;

  logic [rs_depth-1:0] busy;
  logic [rs_depth-1:0] a_rdy;
  logic [rs_depth-1:0] b_rdy;
  alu_op_e             op_q  [rs_depth];
  rob_tag_t            tag_q [rs_depth];
  rob_tag_t            a_tag [rs_depth];
  rob_tag_t            b_tag [rs_depth];
  word_t               a_val [rs_depth];
  word_t               b_val [rs_depth];
  logic [age_w-1:0]    age   [rs_depth];  // 0 is the oldest entry
  logic [age_w-1:0]    occupancy;
  logic [age_w-1:0]    sel_age;
  logic [sel_w-1:0]    sel;
  logic [sel_w-1:0]    free_idx;
  logic                load;

  // oldest entry with both operands ready
  always_comb begin
    issue_valid = 1'b0;
    sel         = '0;
    sel_age     = '0;
    for (int i = 0; i < rs_depth; i++) begin
      if (busy[i] && a_rdy[i] && b_rdy[i] && (!issue_valid || age[i] < sel_age)) begin
        issue_valid = 1'b1;
        sel         = sel_w'(i);
        sel_age     = age[i];
      end
    end
  end

  // lowest empty slot and count of busy ones
  always_comb begin
    dispatch.free = 1'b0;
    free_idx      = '0;
    occupancy     = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        dispatch.free = 1'b1;
        free_idx      = sel_w'(i);
      end else begin
        occupancy = occupancy + 1'b1;
      end
    end
  end

  assign load      = dispatch.valid && dispatch.free;
  assign issue_op  = op_q[sel];
  assign issue_tag = tag_q[sel];
  assign issue_a   = a_val[sel];
  assign issue_b   = b_val[sel];

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
      for (int i = 0; i < rs_depth; i++) begin
        age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < rs_depth; i++) begin
        if (issue_valid && sel == sel_w'(i))
          busy[i] <= 1'b0;
        else if (issue_valid && busy[i] && age[i] > sel_age)
          age[i] <= age[i] - 1'b1;  // younger entries move up
      end
      if (load) begin
        busy[free_idx] <= 1'b1;
        age[free_idx]  <= issue_valid ? occupancy - 1'b1 : occupancy;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (busy[i] && !a_rdy[i] && cdb.valid && cdb.tag == a_tag[i]) begin
        a_val[i] <= cdb.value;
        a_rdy[i] <= 1'b1;
      end
      if (busy[i] && !b_rdy[i] && cdb.valid && cdb.tag == b_tag[i]) begin
        b_val[i] <= cdb.value;
        b_rdy[i] <= 1'b1;
      end
    end
    if (load) begin
      op_q[free_idx]  <= dispatch.op;
      tag_q[free_idx] <= dispatch.tag;
      a_val[free_idx] <= dispatch.src1_value;
      a_tag[free_idx] <= dispatch.src1_tag;
      a_rdy[free_idx] <= dispatch.src1_ready;
      b_tag[free_idx] <= dispatch.src2_tag;
      if (dispatch.op == op_addi) begin
        b_val[free_idx] <= dispatch.imm;  // immediate stands in for rs2
        b_rdy[free_idx] <= 1'b1;
      end else begin
        b_val[free_idx] <= dispatch.src2_value;
        b_rdy[free_idx] <= dispatch.src2_ready;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/tomasulo_core.sv
`default_nettype none

module tomasulo_core #(
  parameter int rob_depth   = 8,  // power of two, up to ROB_DEPTH_MAX
  parameter int rs_depth    = 3,
  parameter int alu_latency = 2
) (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         instr_req,
  input  wire tomasulo_pkg::alu_op_e  instr_op,
  input  wire tomasulo_pkg::reg_addr_t instr_rd,
  input  wire tomasulo_pkg::reg_addr_t instr_rs1,
  input  wire tomasulo_pkg::reg_addr_t instr_rs2,
  input  wire tomasulo_pkg::word_t    instr_imm,
  output logic                        instr_ack,
  output logic                        commit_req,
  output tomasulo_pkg::reg_addr_t     commit_rd,
  output tomasulo_pkg::word_t         commit_value,
  input  wire                         commit_ack
);
  import tomasulo_pkg::*;

  cdb_t     cdb;
  logic     issue_valid;  // station to ALU
  alu_op_e  issue_op;
  rob_tag_t issue_tag;
  word_t    issue_a;
  word_t    issue_b;

  dispatch_if dispatch_bus ();
  rob_if      rob_bus ();

  issue_unit #(.rob_depth(rob_depth)) u_issue (
    .clock(clock), .reset(reset),
    .instr_req(instr_req), .instr_op(instr_op), .instr_rd(instr_rd),
    .instr_rs1(instr_rs1), .instr_rs2(instr_rs2), .instr_imm(instr_imm),
    .instr_ack(instr_ack), .cdb(cdb),
    .dispatch(dispatch_bus.producer), .rob(rob_bus.issue)
  );

  reservation_station #(.rs_depth(rs_depth)) u_rs (
    .clock(clock), .reset(reset),
    .dispatch(dispatch_bus.buffer), .cdb(cdb),
    .issue_valid(issue_valid), .issue_op(issue_op), .issue_tag(issue_tag),
    .issue_a(issue_a), .issue_b(issue_b)
  );

  alu_unit #(.alu_latency(alu_latency)) u_alu (
    .clock(clock), .reset(reset),
    .issue_valid(issue_valid), .issue_op(issue_op), .issue_tag(issue_tag),
    .issue_a(issue_a), .issue_b(issue_b), .cdb(cdb)
  );

  reorder_buffer #(.rob_depth(rob_depth)) u_rob (
    .clock(clock), .reset(reset),
    .rob(rob_bus.buffer), .cdb(cdb),
    .commit_req(commit_req), .commit_rd(commit_rd),
    .commit_value(commit_value), .commit_ack(commit_ack)
  );

endmodule

`default_nettype wire

//--- verif/tb_tomasulo.sv
`default_nettype none

module tb_tomasulo;
  timeunit 1ns;
  timeprecision 1ps;
  import tomasulo_pkg::*;

  localparam int rob_depth      = 8;
  localparam int rs_depth       = 3;
  localparam int alu_latency    = 5;  // longer than the issue handshake, chains wait on the CDB
  localparam logic [31:0] seed  = 32'h6873_b97c;
  localparam int reset_cycles   = 16;
  localparam int n_basic        = 14;
  localparam int n_chain        = 16;
  localparam int n_rewrite      = 20;
  localparam int n_readback     = 2;
  localparam int n_backpressure = 40;
  localparam int n_zero         = 8;
  localparam int n_random       = 200;
  localparam int n_total        = n_basic + n_chain + n_rewrite + n_readback
                                  + n_backpressure + n_zero + n_random;
  localparam int timeout_cycles = n_total * (rob_depth + alu_latency + 8) + reset_cycles;

  logic        clock;
  logic        reset;
  logic        instr_req;
  alu_op_e     instr_op;
  reg_addr_t   instr_rd;
  reg_addr_t   instr_rs1;
  reg_addr_t   instr_rs2;
  word_t       instr_imm;
  logic        instr_ack;
  logic        commit_req;
  reg_addr_t   commit_rd;
  word_t       commit_value;
  logic        commit_ack;

  word_t       model_rf [NUM_REGS];  // architectural state in program order
  reg_addr_t   exp_rd_q [$];
  word_t       exp_value_q [$];
  int          error_count;
  int          check_count;
  int          test_count;
  int          ack_delay_max;         // 0 means ack at once
  int          cycle_count;

  tomasulo_core #(
    .rob_depth(rob_depth), .rs_depth(rs_depth), .alu_latency(alu_latency)
  ) DUT (
    .clock(clock), .reset(reset),
    .instr_req(instr_req), .instr_op(instr_op), .instr_rd(instr_rd),
    .instr_rs1(instr_rs1), .instr_rs2(instr_rs2), .instr_imm(instr_imm),
    .instr_ack(instr_ack), .commit_req(commit_req), .commit_rd(commit_rd),
    .commit_value(commit_value), .commit_ack(commit_ack)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // expected commit of one instruction, x0 never changes
  function automatic void ref_execute(input alu_op_e op, input reg_addr_t rd,
                                      input reg_addr_t rs1, input reg_addr_t rs2,
                                      input word_t imm);
    word_t a;
    word_t b;
    word_t result;
    a = model_rf[rs1];
    b = (op == op_addi) ? imm : model_rf[rs2];
    case (op)
      op_add, op_addi: result = a + b;
      op_sub:          result = a - b;
      op_and:          result = a & b;
      op_or:           result = a | b;
      op_xor:          result = a ^ b;
      op_slt:          result = ($signed(a) < $signed(b)) ? 32'sd1 : 32'sd0;
      default:         result = '0;
    endcase
    if (rd != 5'd0)
      model_rf[rd] = result;
    exp_rd_q.push_back(rd);
    exp_value_q.push_back(result);
  endfunction

  function automatic word_t random_imm();
    return word_t'(int'($urandom_range(8191, 0)) - 4096);  // signed, both polarities
  endfunction

  task automatic send_instr(input alu_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2, input word_t imm);
    @(posedge clock);
    instr_req <= 1'b1;
    instr_op  <= op;
    instr_rd  <= rd;
    instr_rs1 <= rs1;
    instr_rs2 <= rs2;
    instr_imm <= imm;
    ref_execute(op, rd, rs1, rs2, imm);
    do @(posedge clock); while (!instr_ack);
    instr_req <= 1'b0;
    do @(posedge clock); while (instr_ack);
  endtask

  task automatic send_random(input int reg_lo, input int reg_hi);
    send_instr(alu_op_e'($urandom_range(6, 0)), reg_addr_t'($urandom_range(reg_hi, reg_lo)),
               reg_addr_t'($urandom_range(reg_hi, reg_lo)),
               reg_addr_t'($urandom_range(reg_hi, reg_lo)), random_imm());
  endtask

  // all expected commits taken and the last handshake finished
  task automatic wait_drain();
    while (exp_rd_q.size() != 0) @(posedge clock);
    repeat (4) @(posedge clock);
  endtask

  task automatic report_test(input string name, input int n_instr, input int errors_before);
    test_count++;
    $display("test %0d %s: %0d instructions, %0d errors", test_count, name, n_instr,
             error_count - errors_before);
  endtask

  // commit side, optional random delay before ack
  initial begin : compare
    reg_addr_t exp_rd;
    word_t     exp_value;
    int        delay;
    commit_ack = 1'b0;
    forever begin
      @(posedge clock);
      if (!reset && commit_req) begin
        delay = (ack_delay_max > 0) ? int'($urandom_range(ack_delay_max, 0)) : 0;
        repeat (delay) @(posedge clock);
        if (exp_rd_q.size() == 0) begin
          $display("error at %0t: commit of x%0d with no instruction outstanding",
                   $time, commit_rd);
          error_count++;
        end else begin
          exp_rd    = exp_rd_q.pop_front();
          exp_value = exp_value_q.pop_front();
          check_count++;
          if (commit_rd !== exp_rd) begin
            $display("error at %0t: commit_rd expected %0d got %0d", $time, exp_rd, commit_rd);
            error_count++;
          end
          if (commit_value !== exp_value) begin
            $display("error at %0t: commit_value expected %0d got %0d",
                     $time, exp_value, commit_value);
            error_count++;
          end
        end
        commit_ack <= 1'b1;
        do @(posedge clock); while (commit_req);
        commit_ack <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin : stimulus
    int errors_before;
    void'($urandom(seed));
    reset         = 1'b1;
    instr_req     = 1'b0;
    instr_op      = op_add;
    instr_rd      = '0;
    instr_rs1     = '0;
    instr_rs2     = '0;
    instr_imm     = '0;
    error_count   = 0;
    check_count   = 0;
    test_count    = 0;
    ack_delay_max = 0;
    for (int r = 0; r < NUM_REGS; r++)
      model_rf[r] = word_t'(r);  // DUT resets x_k to k
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;

    errors_before = error_count;
    for (int i = 0; i < n_basic; i++)
      send_instr(alu_op_e'(i % 7), reg_addr_t'(i + 1), reg_addr_t'($urandom_range(31, 16)),
                 reg_addr_t'($urandom_range(31, 16)),
                 (i % 2 == 1) ? -word_t'(i * 37) : random_imm());
    wait_drain();
    report_test("independent ops", n_basic, errors_before);

    errors_before = error_count;
    for (int i = 0; i < n_chain; i++)  // rs1 is the previous rd
      send_instr(alu_op_e'($urandom_range(6, 0)), reg_addr_t'(8 + i % 4),
                 reg_addr_t'(8 + (i + 3) % 4), reg_addr_t'($urandom_range(31, 16)),
                 random_imm());
    wait_drain();
    report_test("dependent chain", n_chain, errors_before);

    errors_before = error_count;
    for (int i = 0; i < n_rewrite; i++)
      send_instr(alu_op_e'($urandom_range(6, 0)), reg_addr_t'($urandom_range(7, 6)),
                 reg_addr_t'($urandom_range(7, 5)), reg_addr_t'($urandom_range(7, 5)),
                 random_imm());
    wait_drain();
    send_instr(op_add, 5'd0, 5'd6, 5'd0, '0);  // read back through x0
    send_instr(op_add, 5'd0, 5'd7, 5'd0, '0);
    wait_drain();
    report_test("rewrite same rd", n_rewrite + n_readback, errors_before);

    errors_before = error_count;
    ack_delay_max = 10;
    for (int i = 0; i < n_backpressure; i++)
      send_random(0, 31);
    wait_drain();
    ack_delay_max = 0;
    report_test("commit back-pressure", n_backpressure, errors_before);

    errors_before = error_count;
    for (int i = 0; i < n_zero / 2; i++)
      send_instr(alu_op_e'($urandom_range(6, 0)), 5'd0, reg_addr_t'($urandom_range(31, 1)),
                 reg_addr_t'($urandom_range(31, 1)), random_imm());
    for (int i = 0; i < n_zero / 2; i++)
      send_instr(alu_op_e'((i % 2 == 1) ? op_addi : op_add), reg_addr_t'(20 + i),
                 5'd0, 5'd0, random_imm());
    wait_drain();
    report_test("x0 writes", n_zero, errors_before);

    errors_before = error_count;
    for (int i = 0; i < n_random; i++)
      send_random(0, 31);
    wait_drain();
    report_test("random program", n_random, errors_before);

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tomasulo_asserts.sv
`default_nettype none

module tomasulo_asserts (
  input wire                     clock,
  input wire                     reset,
  input wire                     commit_req,
  input wire                     commit_ack,
  input wire tomasulo_pkg::cdb_t cdb
);
  timeunit 1ns;
  timeprecision 1ps;

  // req stays up until the ack has been seen
  property req_held_until_ack;
    @(posedge clock) disable iff (reset)
      $fell(commit_req) |-> $past(commit_ack);
  endproperty

  // a new commit only starts once ack is back low
  property req_rises_after_ack_low;
    @(posedge clock) disable iff (reset)
      $rose(commit_req) |-> !$past(commit_ack);
  endproperty

  property cdb_tag_known;
    @(posedge clock) disable iff (reset)
      cdb.valid |-> !$isunknown(cdb.tag);
  endproperty

  assert property (req_held_until_ack)
    else $error("commit_req dropped before commit_ack rose");
  assert property (req_rises_after_ack_low)
    else $error("commit_req rose while commit_ack was still high");
  assert property (cdb_tag_known)
    else $error("cdb valid with an unknown tag");

endmodule

bind reorder_buffer tomasulo_asserts u_asserts (
  .clock(clock), .reset(reset), .commit_req(commit_req),
  .commit_ack(commit_ack), .cdb(cdb)
);

`default_nettype wire

//--- vlog.f
common/tomasulo_pkg.sv
common/dispatch_if.sv
common/rob_if.sv
hw/alu_unit.sv
hw/rs/reservation_station.sv
hw/reorder_buffer.sv
hw/issue_unit.sv
hw/tomasulo_core.sv
verif/tomasulo_asserts.sv
verif/tb_tomasulo.sv
